// File: hw/bcdDigitPkg.sv
`default_nettype none

// ==========================================================================
// packed decimal number format
// ==========================================================================
package bcdDigitPkg;

  // bits per decimal digit
  localparam int DIGIT_BITS = 4;

  // largest legal digit value
  localparam int DIGIT_MAX = 9;

  // one packed BCD digit
  typedef logic [DIGIT_BITS-1:0] digitT;

  // raw digit sum or difference, one bit wider than a digit
  // the top bit carries the decimal carry or the borrow sign
  typedef logic [DIGIT_BITS:0] nibbleSumT;

  // low operand digits taken by the multiplier
  // the product spans twice as many digits
  localparam int MUL_DIGITS = 2;

endpackage

`default_nettype wire

// File: hw/bcdOpPkg.sv
`default_nettype none

// ==========================================================================
// operation codes of the decimal unit
// ==========================================================================
package bcdOpPkg;

  // add and sub use the carry/borrow input, mul ignores it
  // nop strobes are dropped at decode and never produce a result
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MUL = 2'd2,
    OP_NOP = 2'd3
  } opT;

  // result flags returned with every valid pulse
  //   carryOut   decimal carry or borrow out of the top digit
  //   midCarry   carry or borrow out of the lower half of the digits
  //   zero       all result digits are zero
  //   badOperand some operand digit was above nine

endpackage

`default_nettype wire

// File: hw/bcdExecIf.sv
`timescale 1ns/1ps
`default_nettype none

// decoded command passed from decode to execute
interface bcdExecIf #(
  parameter int NDIGITS = 4
) ();
  import bcdDigitPkg::*;
  import bcdOpPkg::*;

  // fields are only meaningful while cmdValid is high
  logic                          cmdValid;
  opT                            op;
  logic [NDIGITS*DIGIT_BITS-1:0] a;
  logic [NDIGITS*DIGIT_BITS-1:0] b;
  logic                          carryIn;
  logic                          badOperand;

  modport decoder (
    output cmdValid, op, a, b, carryIn, badOperand
  );

  modport executor (
    input cmdValid, op, a, b, carryIn, badOperand
  );

endinterface

`default_nettype wire

// File: hw/bcdDecode.sv
`timescale 1ns/1ps
`default_nettype none

module bcdDecode #(
  parameter int NDIGITS = 4
) (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       start,
  input  bcdOpPkg::opT                               op,
  input  logic [NDIGITS*bcdDigitPkg::DIGIT_BITS-1:0] a,
  input  logic [NDIGITS*bcdDigitPkg::DIGIT_BITS-1:0] b,
  input  logic                                       carryIn,
  bcdExecIf.decoder                                  bus
);
  import bcdDigitPkg::*;
  import bcdOpPkg::*;

  localparam int W = NDIGITS * DIGIT_BITS;

  logic accept;

  // high when any digit of the operand is above nine
  function automatic logic hasBadDigit(input logic [W-1:0] value);
    logic bad;
    bad = 1'b0;
    for (int i = 0; i < NDIGITS; i++) begin
      if (value[i*DIGIT_BITS +: DIGIT_BITS] > digitT'(DIGIT_MAX)) begin
        bad = 1'b1;
      end
    end
    return bad;
  endfunction

  // nop strobes never enter the pipeline
  assign accept = start && (op != OP_NOP);

  always_ff @(posedge clk) begin
    if (rst) begin
      bus.cmdValid   <= 1'b0;
      bus.op         <= OP_ADD;
      bus.a          <= '0;
      bus.b          <= '0;
      bus.carryIn    <= 1'b0;
      bus.badOperand <= 1'b0;
    end else begin
      bus.cmdValid <= accept;
      if (accept) begin
        bus.op         <= op;
        bus.a          <= a;
        bus.b          <= b;
        bus.carryIn    <= carryIn;
        bus.badOperand <= hasBadDigit(a) || hasBadDigit(b);
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/bcdExecute.sv
`timescale 1ns/1ps
`default_nettype none

module bcdExecute #(
  parameter int NDIGITS = 4
) (
  input  logic                                       clk,
  input  logic                                       rst,
  bcdExecIf.executor                                 bus,
  output logic                                       exValid,
  output logic [NDIGITS*bcdDigitPkg::DIGIT_BITS-1:0] exDigits,
  output logic                                       exCarry,
  output logic                                       exMidCarry,
  output logic                                       exBad
);
  import bcdDigitPkg::*;
  import bcdOpPkg::*;

  localparam int W = NDIGITS * DIGIT_BITS;
  localparam int PAIR_BITS = 2 * DIGIT_BITS;

  typedef struct packed {
    logic           carry;
    logic           mid;
    logic [W-1:0]   digits;
  } chainT;

  // ========================================================================
  // digit-pair product table, indexed by {x, y}
  // ========================================================================
  typedef logic [2**PAIR_BITS-1:0][PAIR_BITS-1:0] mulTableT;

  function automatic mulTableT buildMulTable();
    mulTableT t;
    t = '0;
    for (int i = 0; i <= DIGIT_MAX; i++) begin
      for (int j = 0; j <= DIGIT_MAX; j++) begin
        t[{digitT'(i), digitT'(j)}] = {digitT'((i * j) / 10), digitT'((i * j) % 10)};
      end
    end
    return t;
  endfunction

  // entries with an illegal digit stay zero
  localparam mulTableT MUL_TABLE = buildMulTable();

  // ========================================================================
  // decimal adjust and ripple chains
  // ========================================================================
  // top bit of the return value is the carry, low bits the digit
  function automatic nibbleSumT addAdjust(input nibbleSumT raw);
    if (raw > nibbleSumT'(DIGIT_MAX)) begin
      return {1'b1, digitT'(raw - nibbleSumT'(DIGIT_MAX + 1))};
    end
    return {1'b0, digitT'(raw)};
  endfunction

  // a negative raw difference wraps into 0x16..0x1f
  function automatic nibbleSumT subAdjust(input nibbleSumT raw);
    if (raw[DIGIT_BITS]) begin
      return {1'b1, digitT'(raw + nibbleSumT'(DIGIT_MAX + 1))};
    end
    return {1'b0, digitT'(raw)};
  endfunction

  function automatic chainT rippleAdd(input logic [W-1:0] x, input logic [W-1:0] y,
                                      input logic cin);
    chainT     res;
    logic      c;
    nibbleSumT adj;
    res = '0;
    c   = cin;
    for (int i = 0; i < NDIGITS; i++) begin
      adj = addAdjust(nibbleSumT'(x[i*DIGIT_BITS +: DIGIT_BITS]) +
                      nibbleSumT'(y[i*DIGIT_BITS +: DIGIT_BITS]) + nibbleSumT'(c));
      res.digits[i*DIGIT_BITS +: DIGIT_BITS] = adj[DIGIT_BITS-1:0];
      c = adj[DIGIT_BITS];
      // tap the carry leaving the lower half
      if (i == NDIGITS / 2 - 1) begin
        res.mid = c;
      end
    end
    res.carry = c;
    return res;
  endfunction

  function automatic chainT rippleSub(input logic [W-1:0] x, input logic [W-1:0] y,
                                      input logic bin);
    chainT     res;
    logic      c;
    nibbleSumT adj;
    res = '0;
    c   = bin;
    for (int i = 0; i < NDIGITS; i++) begin
      adj = subAdjust(nibbleSumT'(x[i*DIGIT_BITS +: DIGIT_BITS]) -
                      nibbleSumT'(y[i*DIGIT_BITS +: DIGIT_BITS]) - nibbleSumT'(c));
      res.digits[i*DIGIT_BITS +: DIGIT_BITS] = adj[DIGIT_BITS-1:0];
      c = adj[DIGIT_BITS];
      if (i == NDIGITS / 2 - 1) begin
        res.mid = c;
      end
    end
    res.carry = c;
    return res;
  endfunction

  chainT addRes;
  chainT subRes;
  chainT mulPart;
  chainT mulRes;

  logic [DIGIT_BITS*MUL_DIGITS-1:0] aLo;
  logic [DIGIT_BITS*MUL_DIGITS-1:0] bLo;
  logic [PAIR_BITS-1:0]             p1, p2, p3, p4;

  logic [W-1:0] nextDigits;
  logic         nextCarry;
  logic         nextMid;

  assign addRes = rippleAdd(bus.a, bus.b, bus.carryIn);
  assign subRes = rippleSub(bus.a, bus.b, bus.carryIn);

  // two-digit multiply from four digit-pair products
  assign aLo = bus.a[DIGIT_BITS*MUL_DIGITS-1:0];
  assign bLo = bus.b[DIGIT_BITS*MUL_DIGITS-1:0];
  assign p1  = MUL_TABLE[{aLo[3:0], bLo[3:0]}];
  assign p2  = MUL_TABLE[{aLo[7:4], bLo[3:0]}];
  assign p3  = MUL_TABLE[{aLo[3:0], bLo[7:4]}];
  assign p4  = MUL_TABLE[{aLo[7:4], bLo[7:4]}];

  // cross products sit one digit up
  assign mulPart = rippleAdd(W'({p4, p1}), W'({p2, digitT'(0)}), 1'b0);
  assign mulRes  = rippleAdd(mulPart.digits, W'({p3, digitT'(0)}), 1'b0);

  always_comb begin
    nextDigits = '0;
    nextCarry  = 1'b0;
    nextMid    = 1'b0;
    // an illegal digit forces an all-zero result
    if (!bus.badOperand) begin
      case (bus.op)
        OP_ADD: begin
          nextDigits = addRes.digits;
          nextCarry  = addRes.carry;
          nextMid    = addRes.mid;
        end
        OP_SUB: begin
          nextDigits = subRes.digits;
          nextCarry  = subRes.carry;
          nextMid    = subRes.mid;
        end
        OP_MUL: nextDigits = mulRes.digits;
        default: nextDigits = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      exValid    <= 1'b0;
      exDigits   <= '0;
      exCarry    <= 1'b0;
      exMidCarry <= 1'b0;
      exBad      <= 1'b0;
    end else begin
      exValid <= bus.cmdValid;
      if (bus.cmdValid) begin
        exDigits   <= nextDigits;
        exCarry    <= nextCarry;
        exMidCarry <= nextMid;
        exBad      <= bus.badOperand;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/bcdResult.sv
`timescale 1ns/1ps
`default_nettype none

module bcdResult #(
  parameter int NDIGITS = 4
) (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       exValid,
  input  logic [NDIGITS*bcdDigitPkg::DIGIT_BITS-1:0] exDigits,
  input  logic                                       exCarry,
  input  logic                                       exMidCarry,
  input  logic                                       exBad,
  output logic                                       valid,
  output logic [NDIGITS*bcdDigitPkg::DIGIT_BITS-1:0] result,
  output logic                                       carryOut,
  output logic                                       midCarry,
  output logic                                       zero,
  output logic                                       badOperand
);

  // one valid pulse per command, data follows the same edge
  always_ff @(posedge clk) begin
    if (rst) begin
      valid      <= 1'b0;
      result     <= '0;
      carryOut   <= 1'b0;
      midCarry   <= 1'b0;
      zero       <= 1'b0;
      badOperand <= 1'b0;
    end else begin
      valid <= exValid;
      if (exValid) begin
        result     <= exDigits;
        carryOut   <= exCarry;
        midCarry   <= exMidCarry;
        // every digit zero
        zero       <= ~|exDigits;
        badOperand <= exBad;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/bcdAlu.sv
`timescale 1ns/1ps
`default_nettype none

module bcdAlu #(
  parameter int NDIGITS = 4
) (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       start,
  input  bcdOpPkg::opT                               op,
  input  logic [NDIGITS*bcdDigitPkg::DIGIT_BITS-1:0] a,
  input  logic [NDIGITS*bcdDigitPkg::DIGIT_BITS-1:0] b,
  input  logic                                       carryIn,
  output logic                                       valid,
  output logic [NDIGITS*bcdDigitPkg::DIGIT_BITS-1:0] result,
  output logic                                       carryOut,
  output logic                                       midCarry,
  output logic                                       zero,
  output logic                                       badOperand
);
  import bcdDigitPkg::*;

  // ========================================================================
  // decode -> execute -> result, one cycle per stage
  // ========================================================================
  logic                          exValid;
  logic [NDIGITS*DIGIT_BITS-1:0] exDigits;
  logic                          exCarry;
  logic                          exMidCarry;
  logic                          exBad;

  // half-way tap and the multiplier both need an even width of four or more
  if ((NDIGITS % 2) != 0 || NDIGITS < 2 * MUL_DIGITS) begin : gBadWidth
    $error("bcdAlu: NDIGITS must be even and at least %0d", 2 * MUL_DIGITS);
  end

  bcdExecIf #(.NDIGITS(NDIGITS)) execBus ();

  bcdDecode #(.NDIGITS(NDIGITS)) uDecode (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .op      (op),
    .a       (a),
    .b       (b),
    .carryIn (carryIn),
    .bus     (execBus.decoder)
  );

  bcdExecute #(.NDIGITS(NDIGITS)) uExecute (
    .clk        (clk),
    .rst        (rst),
    .bus        (execBus.executor),
    .exValid    (exValid),
    .exDigits   (exDigits),
    .exCarry    (exCarry),
    .exMidCarry (exMidCarry),
    .exBad      (exBad)
  );

  bcdResult #(.NDIGITS(NDIGITS)) uResult (
    .clk        (clk),
    .rst        (rst),
    .exValid    (exValid),
    .exDigits   (exDigits),
    .exCarry    (exCarry),
    .exMidCarry (exMidCarry),
    .exBad      (exBad),
    .valid      (valid),
    .result     (result),
    .carryOut   (carryOut),
    .midCarry   (midCarry),
    .zero       (zero),
    .badOperand (badOperand)
  );

endmodule

`default_nettype wire

// File: tb/bcdAlu_assert.sv
`timescale 1ns/1ps
`default_nettype none

module bcdAluAssert #(
  parameter int NDIGITS = 4
) (
  input logic                                       clk,
  input logic                                       rst,
  input logic                                       start,
  input bcdOpPkg::opT                               op,
  input logic                                       valid,
  input logic [NDIGITS*bcdDigitPkg::DIGIT_BITS-1:0] result,
  input logic                                       zero
);
  import bcdOpPkg::*;

  // no pulse while held in reset or on the first cycle out of it
  validLowInReset: assert property (@(posedge clk) rst |=> !valid)
    else $error("valid high during or right after reset");

  // an idle or nop input cycle never shows up at the output
  noPulseAfterIdle: assert property (@(posedge clk) disable iff (rst)
    (!start || op == OP_NOP) |-> ##3 !valid)
    else $error("valid pulse without an accepted command");

  zeroMatchesResult: assert property (@(posedge clk) disable iff (rst)
    valid |-> (zero == (result == '0)))
    else $error("zero flag does not match the result digits");

endmodule

bind bcdAlu bcdAluAssert #(.NDIGITS(NDIGITS)) uAssert (
  .clk    (clk),
  .rst    (rst),
  .start  (start),
  .op     (op),
  .valid  (valid),
  .result (result),
  .zero   (zero)
);

`default_nettype wire

// File: tb/bcdAluTb.sv
`timescale 1ns/1ps
`default_nettype none

module bcdAluTb;
  import bcdDigitPkg::*;
  import bcdOpPkg::*;

  localparam int NDIGITS     = 4;
  localparam int W           = NDIGITS * DIGIT_BITS;
  localparam int NUM_RANDOM  = 400;
  localparam int DRAIN_LIMIT = 50;

  // expected response of one accepted command
  typedef struct packed {
    int unsigned  dueCycle;
    logic [W-1:0] digits;
    logic         carry;
    logic         mid;
    logic         zero;
    logic         bad;
  } expectT;

  logic         clk;
  logic         rst;
  logic         start;
  opT           op;
  logic [W-1:0] a;
  logic [W-1:0] b;
  logic         carryIn;
  logic         valid;
  logic [W-1:0] result;
  logic         carryOut;
  logic         midCarry;
  logic         zero;
  logic         badOperand;

  integer      seed;
  int unsigned cycleCount   = 0;
  int          sentCount    = 0;
  int          checkedCount = 0;
  expectT      expQ[$];

  bcdAlu #(.NDIGITS(NDIGITS)) DUT (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .op         (op),
    .a          (a),
    .b          (b),
    .carryIn    (carryIn),
    .valid      (valid),
    .result     (result),
    .carryOut   (carryOut),
    .midCarry   (midCarry),
    .zero       (zero),
    .badOperand (badOperand)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk) cycleCount <= cycleCount + 32'd1;

  // ==========================================================================
  // reference model
  // ==========================================================================
  function automatic int pow10(input int k);
    int r;
    r = 1;
    for (int i = 0; i < k; i++) begin
      r = r * 10;
    end
    return r;
  endfunction

  function automatic int toInt(input logic [W-1:0] v);
    int r;
    r = 0;
    for (int i = NDIGITS - 1; i >= 0; i--) begin
      r = r * 10 + int'(v[i*DIGIT_BITS +: DIGIT_BITS]);
    end
    return r;
  endfunction

  function automatic logic [W-1:0] toBcd(input int n);
    logic [W-1:0] v;
    int           rest;
    rest = n;
    for (int i = 0; i < NDIGITS; i++) begin
      v[i*DIGIT_BITS +: DIGIT_BITS] = digitT'(rest % 10);
      rest = rest / 10;
    end
    return v;
  endfunction

  function automatic logic hasIllegal(input logic [W-1:0] v);
    logic bad;
    bad = 1'b0;
    for (int i = 0; i < NDIGITS; i++) begin
      if (int'(v[i*DIGIT_BITS +: DIGIT_BITS]) > 9) begin
        bad = 1'b1;
      end
    end
    return bad;
  endfunction

  function automatic expectT buildExpect(input opT cmdOp, input logic [W-1:0] x,
                                         input logic [W-1:0] y, input logic cin);
    expectT e;
    int     ix;
    int     iy;
    int     full;
    int     half;
    int     raw;
    int     lowRaw;
    e = '0;
    // any illegal digit gives an all-zero result, whatever the opcode
    if (hasIllegal(x) || hasIllegal(y)) begin
      e.bad  = 1'b1;
      e.zero = 1'b1;
      return e;
    end
    ix   = toInt(x);
    iy   = toInt(y);
    full = pow10(NDIGITS);
    half = pow10(NDIGITS / 2);
    case (cmdOp)
      OP_ADD: begin
        raw      = ix + iy + int'(cin);
        lowRaw   = ix % half + iy % half + int'(cin);
        e.carry  = (raw >= full);
        e.mid    = (lowRaw >= half);
        e.digits = toBcd(raw % full);
      end
      OP_SUB: begin
        raw    = ix - iy - int'(cin);
        lowRaw = ix % half - iy % half - int'(cin);
        e.carry = (raw < 0);
        e.mid   = (lowRaw < 0);
        if (raw < 0) begin
          raw = raw + full;
        end
        e.digits = toBcd(raw);
      end
      OP_MUL: begin
        raw      = (ix % pow10(MUL_DIGITS)) * (iy % pow10(MUL_DIGITS));
        e.digits = toBcd(raw);
      end
      default: e.digits = '0;
    endcase
    e.zero = (e.digits == '0);
    return e;
  endfunction

  // ==========================================================================
  // random helpers and stimulus
  // ==========================================================================
  function automatic int unsigned randBelow(input int unsigned n);
    return {$random(seed)} % n;
  endfunction

  function automatic logic [W-1:0] randomOperand();
    logic [W-1:0] v;
    for (int i = 0; i < NDIGITS; i++) begin
      v[i*DIGIT_BITS +: DIGIT_BITS] = digitT'(randBelow(10));
    end
    return v;
  endfunction

  // overwrite one digit with a value from 10 to 15
  function automatic logic [W-1:0] corruptDigit(input logic [W-1:0] v);
    logic [W-1:0] r;
    int           idx;
    r   = v;
    idx = int'(randBelow(NDIGITS));
    r[idx*DIGIT_BITS +: DIGIT_BITS] = digitT'(10 + randBelow(6));
    return r;
  endfunction

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic checkValue(input string what, input logic [31:0] got,
                            input logic [31:0] expected);
    if (got !== expected) begin
      abortRun($sformatf("FAILED at time %0t: %s is %0h, expected %0h",
                         $time, what, got, expected));
    end
  endtask

  // one input cycle, the model result is queued for accepted commands
  task automatic sendCommand(input logic go, input opT cmdOp, input logic [W-1:0] x,
                             input logic [W-1:0] y, input logic cin);
    expectT e;
    @(posedge clk);
    #1;
    start   = go;
    op      = cmdOp;
    a       = x;
    b       = y;
    carryIn = cin;
    if (go && cmdOp != OP_NOP) begin
      e          = buildExpect(cmdOp, x, y, cin);
      e.dueCycle = cycleCount + 32'd3;
      expQ.push_back(e);
      sentCount++;
    end
  endtask

  // ==========================================================================
  // output checker, samples mid-cycle
  // ==========================================================================
  always @(negedge clk) begin
    expectT e;
    if (!rst) begin
      if (valid) begin
        if (expQ.size() == 0) begin
          abortRun("valid pulse seen while no command was in flight");
        end else begin
          e = expQ.pop_front();
          checkValue("valid cycle", cycleCount, e.dueCycle);
          checkValue("result", 32'(result), 32'(e.digits));
          checkValue("carryOut", 32'(carryOut), 32'(e.carry));
          checkValue("midCarry", 32'(midCarry), 32'(e.mid));
          checkValue("zero", 32'(zero), 32'(e.zero));
          checkValue("badOperand", 32'(badOperand), 32'(e.bad));
          checkedCount++;
        end
      end else if (expQ.size() != 0 && cycleCount >= expQ[0].dueCycle) begin
        abortRun("valid pulse did not arrive in the expected cycle");
      end
    end
  end

  initial begin
    #100000;
    abortRun("simulation watchdog expired before the run completed");
  end

  initial begin
    logic [W-1:0] x;
    logic [W-1:0] y;
    opT           cmdOp;
    int unsigned  pick;
    logic         cin;
    int           drainCycles;
    seed    = 89518;
    rst     = 1'b1;
    start   = 1'b0;
    op      = OP_NOP;
    a       = '0;
    b       = '0;
    carryIn = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    // directed corners, back to back
    sendCommand(1'b1, OP_ADD, 16'h9999, 16'h0001, 1'b0);
    sendCommand(1'b1, OP_ADD, 16'h0000, 16'h0000, 1'b0);
    sendCommand(1'b1, OP_ADD, 16'h4999, 16'h5000, 1'b1);
    sendCommand(1'b1, OP_SUB, 16'h0000, 16'h0001, 1'b0);
    sendCommand(1'b1, OP_SUB, 16'h1000, 16'h0001, 1'b0);
    sendCommand(1'b1, OP_SUB, 16'h5000, 16'h4999, 1'b1);
    sendCommand(1'b1, OP_NOP, 16'h1234, 16'h4321, 1'b0);
    sendCommand(1'b1, OP_MUL, 16'h0099, 16'h0099, 1'b1);
    sendCommand(1'b1, OP_MUL, 16'h0025, 16'h0018, 1'b0);
    sendCommand(1'b1, OP_MUL, 16'h1234, 16'h5678, 1'b0);
    sendCommand(1'b0, OP_ADD, 16'h0001, 16'h0001, 1'b0);
    // illegal digits for every opcode
    sendCommand(1'b1, OP_ADD, 16'h00a0, 16'h0001, 1'b1);
    sendCommand(1'b1, OP_SUB, 16'h0001, 16'hf000, 1'b0);
    sendCommand(1'b1, OP_MUL, 16'h000b, 16'h0002, 1'b0);

    for (int n = 0; n < NUM_RANDOM; n++) begin
      pick  = randBelow(16);
      x     = randomOperand();
      y     = randomOperand();
      cin   = (randBelow(2) != 0);
      cmdOp = opT'(randBelow(3));
      if (randBelow(8) == 0) begin
        if (randBelow(2) == 0) begin
          x = corruptDigit(x);
        end else begin
          y = corruptDigit(y);
        end
      end
      if (pick < 2) begin
        sendCommand(1'b0, cmdOp, x, y, cin);
      end else if (pick < 3) begin
        sendCommand(1'b1, OP_NOP, x, y, cin);
      end else begin
        sendCommand(1'b1, cmdOp, x, y, cin);
      end
    end
    sendCommand(1'b0, OP_NOP, '0, '0, 1'b0);

    drainCycles = 0;
    while (expQ.size() != 0 && drainCycles < DRAIN_LIMIT) begin
      @(posedge clk);
      drainCycles++;
    end
    if (expQ.size() != 0) begin
      abortRun($sformatf("timeout: %0d results never came out", expQ.size()));
    end else begin
      // a few quiet cycles so that a stray pulse would still be caught
      repeat (4) @(posedge clk);
      if (checkedCount == sentCount) begin
        $display("ALL TESTS PASSED");
        $finish;
      end else begin
        abortRun("number of checked results differs from commands sent");
      end
    end
  end

endmodule

`default_nettype wire

// File: project.f
hw/bcdDigitPkg.sv
hw/bcdOpPkg.sv
hw/bcdExecIf.sv
hw/bcdDecode.sv
hw/bcdExecute.sv
hw/bcdResult.sv
hw/bcdAlu.sv
tb/bcdAlu_assert.sv
tb/bcdAluTb.sv

// File: run.sh
#!/usr/bin/env bash
# build the bcdAlu testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module bcdAluTb -f project.f -o bcdAluSim \
  && ./obj_dir/bcdAluSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "SOME TESTS FAILED" sim.log 2>/dev/null && { echo "simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log 2>/dev/null || { echo "simulation failed"; exit 1; }
echo "simulation passed"
